// ==== design/dfi_mon_pkg.sv ====
/*
 DFI protocol monitor package
 Command codes, timing limits, preamble table and shared bus types
*/
`default_nettype none

package dfi_mon_pkg;

	// ----------------------------------------
	// Widths and plain vector types
	// ----------------------------------------
	localparam int CA_W = 14;
	localparam int GAP_W = 4;
	localparam int PRE_MAX = 8;

	typedef logic [CA_W-1:0] ca_t;
	typedef logic [2:0] bank_t;
	typedef logic [1:0] bank_grp_t;
	typedef logic [7:0] mr_addr_t;
	typedef logic [7:0] mr_op_t;
	typedef logic [2:0] pre_code_t;
	typedef logic [3:0] pre_len_t;
	typedef logic [PRE_MAX-1:0] pre_pat_t;
	// Cycles since a command, sticks at all ones
	typedef logic [GAP_W-1:0] gap_t;

	localparam gap_t GAP_MAX = '1;

	// ----------------------------------------
	// Command encodings on CA[4:0]
	// ----------------------------------------
	localparam logic [4:0] OPC_MRR = 5'b10101;
	localparam logic [4:0] OPC_MRW = 5'b00101;
	localparam logic [4:0] OPC_PRE = 5'b01011;
	localparam logic [4:0] OPC_RD = 5'b11101;
	// ACT only looks at the two low bits
	localparam logic [1:0] OPC_ACT_LO = 2'b00;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_MRR,
		OP_MRW,
		OP_PRE,
		OP_RD,
		OP_ACT
	} cmd_op_e;

	// Minimum spacings, in clock cycles
	localparam int T_MRR = 3;
	localparam int T_MRW = 4;
	localparam int T_MRD = 6;
	localparam int T_RP = 3;
	localparam int T_RRD_S = 2;
	localparam int T_RRD_L = 4;
	localparam int RL = 10;

	// Mode registers with reserved bits
	localparam mr_addr_t MR_PREAMBLE_ADDR = 8'd8;
	localparam mr_addr_t MR0_ADDR = 8'h00;
	localparam mr_addr_t MR40_ADDR = 8'h28;
	localparam mr_op_t RFU_MASK_MR0 = 8'h80;
	localparam mr_op_t RFU_MASK_MR8 = 8'h20;
	localparam mr_op_t RFU_MASK_MR40 = 8'hf8;

	// Preamble per MR8 code, newest DQS sample in bit 0
	localparam logic [7:0][3:0] PRE_LEN = {4'd2, 4'd2, 4'd2, 4'd8, 4'd6, 4'd4, 4'd4, 4'd2};
	localparam logic [7:0][PRE_MAX-1:0] PRE_PATTERN = {
		8'b0000_0010,
		8'b0000_0010,
		8'b0000_0010,
		8'b0000_1010,
		8'b0000_0010,
		8'b0000_1110,
		8'b0000_0010,
		8'b0000_0010
	};

	// ----------------------------------------
	// Structs between the checkers
	// ----------------------------------------
	typedef struct packed {
		logic valid;
		cmd_op_e op;
		bank_t bank;
		bank_grp_t bank_grp;
		mr_addr_t mr_addr;
		logic mrw_data_valid;
		mr_op_t mr_op;
	} cmd_t;

	typedef struct packed {
		logic mrr_spacing;
		logic mrw_spacing;
		logic pre_spacing;
		logic act_spacing;
		logic closed_bank_read;
		logic rfu_write;
		logic preamble;
	} violation_t;

endpackage

`default_nettype wire

// ==== design/dfi_cmd_decode.sv ====
/*
 DFI command decoder
 Samples CS and CA, sorts each cycle into a command or an MRW data phase
*/
`timescale 1ns/10ps
`default_nettype none

module dfi_cmd_decode
	import dfi_mon_pkg::*;
(
	input logic dfi_phy_clk,
	input logic rst_n_i,
	input logic cs_n_i,
	input ca_t ca_i,
	output cmd_t cmd_o
);

	logic cs_n_q;
	ca_t ca_q;
	cmd_t cmd_d;
	cmd_t cmd_q;
	logic data_phase;

	// ----------------------------------------
	// Bus sample stage
	// ----------------------------------------
	always_ff @(posedge dfi_phy_clk) begin
		if (!rst_n_i) begin
			// Idle bus after reset
			cs_n_q <= 1'b1;
		end else begin
			cs_n_q <= cs_n_i;
		end
	end

	always_ff @(posedge dfi_phy_clk) begin
		ca_q <= ca_i;
	end

	// Cycle after an MRW carries the operand
	assign data_phase = cmd_q.valid && (cmd_q.op == OP_MRW);

	always_comb begin
		cmd_d = '0;
		cmd_d.op = OP_NONE;
		// Field slices, qualified later by op
		cmd_d.bank = ca_q[8:6];
		cmd_d.bank_grp = ca_q[10:9];
		cmd_d.mr_addr = ca_q[12:5];
		cmd_d.mr_op = ca_q[7:0];
		if (data_phase) begin
			// Never a command, whatever CS does
			cmd_d.mrw_data_valid = 1'b1;
		end else if (!cs_n_q) begin
			case (ca_q[4:0])
				OPC_MRR: cmd_d.op = OP_MRR;
				OPC_MRW: cmd_d.op = OP_MRW;
				OPC_PRE: cmd_d.op = OP_PRE;
				OPC_RD: cmd_d.op = OP_RD;
				default: begin
					if (ca_q[1:0] == OPC_ACT_LO) begin
						cmd_d.op = OP_ACT;
					end
				end
			endcase
			// Unknown opcodes are dropped
			cmd_d.valid = (cmd_d.op != OP_NONE);
		end
	end

	// ----------------------------------------
	// Decoded command register
	// ----------------------------------------
	always_ff @(posedge dfi_phy_clk) begin
		if (!rst_n_i) begin
			cmd_q.valid <= 1'b0;
			cmd_q.op <= OP_NONE;
			cmd_q.mrw_data_valid <= 1'b0;
		end else begin
			cmd_q <= cmd_d;
		end
	end

	assign cmd_o = cmd_q;

endmodule

`default_nettype wire

// ==== design/dfi_cmd_spacing.sv ====
/*
 Command spacing checker
 Gap counters for MRR, MRW and PRE spacing and for ACT to ACT spacing
*/
`timescale 1ns/10ps
`default_nettype none

module dfi_cmd_spacing
	import dfi_mon_pkg::*;
(
	input logic dfi_phy_clk,
	input logic rst_n_i,
	input cmd_t cmd_i,
	output logic mrr_spacing_o,
	output logic mrw_spacing_o,
	output logic pre_spacing_o,
	output logic act_spacing_o
);

	// Gap is the edge distance between two command cycles
	gap_t cmd_gap;
	gap_t act_gap;
	cmd_op_e last_op;
	bank_grp_t last_grp;
	logic is_act;
	logic mrr_hit;
	logic mrw_hit;
	logic pre_hit;
	logic act_hit;

	assign is_act = cmd_i.valid && (cmd_i.op == OP_ACT);

	// ----------------------------------------
	// Rule compare against the last command
	// ----------------------------------------
	always_comb begin
		mrr_hit = 1'b0;
		mrw_hit = 1'b0;
		pre_hit = 1'b0;
		act_hit = 1'b0;
		if (cmd_i.valid) begin
			case (last_op)
				OP_MRR: mrr_hit = (cmd_gap <= gap_t'(T_MRR));
				OP_MRW: begin
					// MRW after MRW has the shorter limit
					if (cmd_i.op == OP_MRW) begin
						mrw_hit = (cmd_gap <= gap_t'(T_MRW));
					end else begin
						mrw_hit = (cmd_gap <= gap_t'(T_MRD));
					end
				end
				OP_PRE: pre_hit = (cmd_gap <= gap_t'(T_RP));
				default: ;
			endcase
		end
		if (is_act) begin
			// Same group needs the long spacing
			if (cmd_i.bank_grp == last_grp) begin
				act_hit = (act_gap <= gap_t'(T_RRD_L));
			end else begin
				act_hit = (act_gap <= gap_t'(T_RRD_S));
			end
		end
	end

	// ----------------------------------------
	// Counters and flag registers
	// ----------------------------------------
	always_ff @(posedge dfi_phy_clk) begin
		if (!rst_n_i) begin
			// Counters start saturated after reset
			cmd_gap <= GAP_MAX;
			act_gap <= GAP_MAX;
			last_op <= OP_NONE;
			mrr_spacing_o <= 1'b0;
			mrw_spacing_o <= 1'b0;
			pre_spacing_o <= 1'b0;
			act_spacing_o <= 1'b0;
		end else begin
			if (cmd_i.valid) begin
				cmd_gap <= gap_t'(1);
				last_op <= cmd_i.op;
			end else if (cmd_gap != GAP_MAX) begin
				cmd_gap <= cmd_gap + gap_t'(1);
			end
			if (is_act) begin
				act_gap <= gap_t'(1);
			end else if (act_gap != GAP_MAX) begin
				act_gap <= act_gap + gap_t'(1);
			end
			mrr_spacing_o <= mrr_hit;
			mrw_spacing_o <= mrw_hit;
			pre_spacing_o <= pre_hit;
			act_spacing_o <= act_hit;
		end
	end

	// Bank group of the last ACT
	always_ff @(posedge dfi_phy_clk) begin
		if (is_act) begin
			last_grp <= cmd_i.bank_grp;
		end
	end

endmodule

`default_nettype wire

// ==== design/dfi_bank_tracker.sv ====
/*
 Bank state tracker
 Keeps the open bank mask and flags reads to banks that are closed
*/
`timescale 1ns/10ps
`default_nettype none

module dfi_bank_tracker
	import dfi_mon_pkg::*;
(
	input logic dfi_phy_clk,
	input logic rst_n_i,
	input cmd_t cmd_i,
	output logic closed_bank_read_o
);

	// One bit per bank, set while the bank is open
	logic [7:0] open_mask;
	logic rd_closed;

	assign rd_closed = cmd_i.valid && (cmd_i.op == OP_RD) && !open_mask[cmd_i.bank];

	always_ff @(posedge dfi_phy_clk) begin
		if (!rst_n_i) begin
			// All banks idle after reset
			open_mask <= '0;
			closed_bank_read_o <= 1'b0;
		end else begin
			if (cmd_i.valid) begin
				case (cmd_i.op)
					OP_ACT: open_mask[cmd_i.bank] <= 1'b1;
					OP_PRE: open_mask[cmd_i.bank] <= 1'b0;
					default: ;
				endcase
			end
			closed_bank_read_o <= rd_closed;
		end
	end

endmodule

`default_nettype wire

// ==== design/dfi_mode_reg.sv ====
/*
 Mode register write checker
 Tracks the MR8 preamble code and flags writes that set RFU bits
*/
`timescale 1ns/10ps
`default_nettype none

module dfi_mode_reg
	import dfi_mon_pkg::*;
(
	input logic dfi_phy_clk,
	input logic rst_n_i,
	input cmd_t cmd_i,
	output pre_code_t pre_code_o,
	output logic rfu_write_o
);

	// Address of the MRW waiting for its operand
	mr_addr_t mrw_addr;
	mr_op_t rfu_mask;
	logic rfu_hit;

	always_ff @(posedge dfi_phy_clk) begin
		if (cmd_i.valid && (cmd_i.op == OP_MRW)) begin
			mrw_addr <= cmd_i.mr_addr;
		end
	end

	// ----------------------------------------
	// Reserved bit lookup
	// ----------------------------------------
	always_comb begin
		case (mrw_addr)
			MR0_ADDR: rfu_mask = RFU_MASK_MR0;
			MR_PREAMBLE_ADDR: rfu_mask = RFU_MASK_MR8;
			MR40_ADDR: rfu_mask = RFU_MASK_MR40;
			// No reserved bits known elsewhere
			default: rfu_mask = '0;
		endcase
	end

	assign rfu_hit = cmd_i.mrw_data_valid && |(cmd_i.mr_op & rfu_mask);

	always_ff @(posedge dfi_phy_clk) begin
		if (!rst_n_i) begin
			pre_code_o <= '0;
			rfu_write_o <= 1'b0;
		end else begin
			rfu_write_o <= rfu_hit;
			// MR8 updates even when the write is illegal
			if (cmd_i.mrw_data_valid && (mrw_addr == MR_PREAMBLE_ADDR)) begin
				pre_code_o <= cmd_i.mr_op[2:0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/dfi_rd_preamble_check.sv ====
/*
 Read preamble checker
 Delays each read by RL and compares the DQS history with the MR8 pattern
*/
`timescale 1ns/10ps
`default_nettype none

module dfi_rd_preamble_check
	import dfi_mon_pkg::*;
(
	input logic dfi_phy_clk,
	input logic rst_n_i,
	input cmd_t cmd_i,
	input pre_code_t pre_code_i,
	input logic dqs_i,
	output logic preamble_o
);

	// Read markers, several may be in flight
	logic [RL-1:0] rd_mark;
	pre_code_t code_dly [RL];
	logic dqs_q;
	// Bit 0 holds the newest DQS sample
	pre_pat_t dqs_hist;
	pre_code_t exit_code;
	pre_len_t exit_len;
	pre_pat_t len_mask;
	logic mismatch;

	// ----------------------------------------
	// Read delay line
	// ----------------------------------------
	always_ff @(posedge dfi_phy_clk) begin
		if (!rst_n_i) begin
			rd_mark <= '0;
		end else begin
			rd_mark <= {rd_mark[RL-2:0], cmd_i.valid && (cmd_i.op == OP_RD)};
		end
	end

	// Code as it stood when the read was decoded
	always_ff @(posedge dfi_phy_clk) begin
		code_dly[0] <= pre_code_i;
		for (int i = 1; i < RL; i++) begin
			code_dly[i] <= code_dly[i-1];
		end
	end

	// ----------------------------------------
	// DQS sample and history
	// ----------------------------------------
	always_ff @(posedge dfi_phy_clk) begin
		if (!rst_n_i) begin
			dqs_q <= 1'b0;
			dqs_hist <= '0;
		end else begin
			dqs_q <= dqs_i;
			dqs_hist <= {dqs_hist[PRE_MAX-2:0], dqs_q};
		end
	end

	// Window ends on the sample RL edges after the read
	assign exit_code = code_dly[RL-1];
	assign exit_len = PRE_LEN[exit_code];
	assign len_mask = {PRE_MAX{1'b1}} >> (PRE_MAX - int'(exit_len));
	assign mismatch = (dqs_hist & len_mask) != PRE_PATTERN[exit_code];

	always_ff @(posedge dfi_phy_clk) begin
		if (!rst_n_i) begin
			preamble_o <= 1'b0;
		end else begin
			preamble_o <= rd_mark[RL-1] && mismatch;
		end
	end

endmodule

`default_nettype wire

// ==== design/dfi_protocol_monitor.sv ====
/*
 DFI protocol monitor top
 Decoder and rule checkers, flags gathered into one violation struct
*/
`timescale 1ns/10ps
`default_nettype none

module dfi_protocol_monitor
	import dfi_mon_pkg::*;
(
	input logic dfi_phy_clk,
	input logic rst_n_i,
	input logic cs_n_i,
	input ca_t ca_i,
	input logic dqs_i,
	output violation_t viol_o
);

	cmd_t cmd;
	pre_code_t pre_code;

	// ----------------------------------------
	// Command decode
	// ----------------------------------------
	dfi_cmd_decode u_cmd_decode (
		.dfi_phy_clk(dfi_phy_clk),
		.rst_n_i(rst_n_i),
		.cs_n_i(cs_n_i),
		.ca_i(ca_i),
		.cmd_o(cmd)
	);

	// ----------------------------------------
	// Rule checkers
	// ----------------------------------------
	dfi_cmd_spacing u_cmd_spacing (
		.dfi_phy_clk(dfi_phy_clk),
		.rst_n_i(rst_n_i),
		.cmd_i(cmd),
		.mrr_spacing_o(viol_o.mrr_spacing),
		.mrw_spacing_o(viol_o.mrw_spacing),
		.pre_spacing_o(viol_o.pre_spacing),
		.act_spacing_o(viol_o.act_spacing)
	);

	dfi_bank_tracker u_bank_tracker (
		.dfi_phy_clk(dfi_phy_clk),
		.rst_n_i(rst_n_i),
		.cmd_i(cmd),
		.closed_bank_read_o(viol_o.closed_bank_read)
	);

	// MR8 code feeds the preamble check as a level
	dfi_mode_reg u_mode_reg (
		.dfi_phy_clk(dfi_phy_clk),
		.rst_n_i(rst_n_i),
		.cmd_i(cmd),
		.pre_code_o(pre_code),
		.rfu_write_o(viol_o.rfu_write)
	);

	dfi_rd_preamble_check u_rd_preamble_check (
		.dfi_phy_clk(dfi_phy_clk),
		.rst_n_i(rst_n_i),
		.cmd_i(cmd),
		.pre_code_i(pre_code),
		.dqs_i(dqs_i),
		.preamble_o(viol_o.preamble)
	);

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
/*
 Testbench clock and reset
 20 ns clock, active low reset held for the first 4 cycles
*/
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int HALF_PERIOD = 10;
	localparam int RST_CYCLES = 4;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// ==== test/tb_dfi_protocol_monitor.sv ====
/*
 Testbench for the DFI protocol monitor
 Drives command and DQS traffic, checks every violation flag each cycle
*/
`timescale 1ns/10ps
`default_nettype none

module tb_dfi_protocol_monitor
	import dfi_mon_pkg::*;
();

	localparam int RST_CYCLES = 4;
	localparam int MAX_CYC = 2048;
	localparam int LEN_SPACING = 400;
	localparam int LEN_ACT = 400;
	localparam int LEN_BANK = 300;
	localparam int LEN_RFU = 220;
	localparam int LEN_PRE = 260;
	localparam int LEN_TOTAL = LEN_SPACING + LEN_ACT + LEN_BANK + LEN_RFU + LEN_PRE;
	// Reset plus all tests back to back plus the read latency and some slack
	localparam int TIMEOUT_CYC = RST_CYCLES + LEN_TOTAL + RL + 20;

	logic dfi_phy_clk;
	logic rst_n_i;
	logic cs_n_i;
	ca_t ca_i;
	logic dqs_i;
	violation_t viol_o;

	int cyc = 0;
	logic [31:0] lfsr;
	violation_t exp_arr [MAX_CYC];
	logic dqs_sched [MAX_CYC];
	string test_name;
	int test_t0;
	int test_err0;
	int err_cnt;
	int pass_cnt;
	int fail_cnt;

	// ----------------------------------------
	// Reference model state
	// ----------------------------------------
	logic mrw_pend_m;
	mr_addr_t mrw_addr_m;
	int last_cmd_n;
	cmd_op_e last_op_m;
	int last_act_n;
	bank_grp_t last_grp_m;
	logic [7:0] open_m;
	pre_code_t pre_code_m;
	// Newest DQS sample in bit 0
	logic [7:0] dqs_m;
	logic rd_m [MAX_CYC];
	pre_code_t rd_code_m [MAX_CYC];

	tb_clk_gen u_clk_gen (
		.clk_o(dfi_phy_clk),
		.rst_n_o(rst_n_i)
	);

	dfi_protocol_monitor u_dut (
		.dfi_phy_clk(dfi_phy_clk),
		.rst_n_i(rst_n_i),
		.cs_n_i(cs_n_i),
		.ca_i(ca_i),
		.dqs_i(dqs_i),
		.viol_o(viol_o)
	);

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic int pre_len(input pre_code_t code);
		case (code)
			3'd1, 3'd2: return 4;
			3'd3: return 6;
			3'd4: return 8;
			default: return 2;
		endcase
	endfunction

	// Oldest sample in the highest used bit
	function automatic logic [7:0] pre_pat(input pre_code_t code);
		case (code)
			3'd1: return 8'b0010;
			3'd2: return 8'b1110;
			3'd3: return 8'b00_0010;
			3'd4: return 8'b0000_1010;
			default: return 8'b10;
		endcase
	endfunction

	function automatic mr_op_t rfu_mask(input mr_addr_t addr);
		case (addr)
			8'h00: return 8'b1000_0000;
			8'h08: return 8'b0010_0000;
			8'h28: return 8'b1111_1000;
			default: return 8'h00;
		endcase
	endfunction

	// ----------------------------------------
	// One bus sample through the rule model
	// ----------------------------------------
	function automatic violation_t ref_step(input int n, input logic cs_n, input ca_t ca,
			input logic dqs);
		violation_t v;
		cmd_op_e op;
		int gap;
		pre_code_t code;
		logic [7:0] mask;
		v = '0;
		op = OP_NONE;
		dqs_m = {dqs_m[6:0], dqs};
		if (mrw_pend_m) begin
			// Operand cycle of the previous MRW
			mrw_pend_m = 1'b0;
			v.rfu_write = |(ca[7:0] & rfu_mask(mrw_addr_m));
			if (mrw_addr_m == 8'd8) begin
				pre_code_m = ca[2:0];
			end
		end else if (!cs_n) begin
			case (ca[4:0])
				5'b10101: op = OP_MRR;
				5'b00101: op = OP_MRW;
				5'b01011: op = OP_PRE;
				5'b11101: op = OP_RD;
				default: begin
					if (ca[1:0] == 2'b00) begin
						op = OP_ACT;
					end
				end
			endcase
		end
		if (op != OP_NONE) begin
			gap = n - last_cmd_n;
			case (last_op_m)
				OP_MRR: v.mrr_spacing = (gap <= T_MRR);
				OP_MRW: v.mrw_spacing = (gap <= ((op == OP_MRW) ? T_MRW : T_MRD));
				OP_PRE: v.pre_spacing = (gap <= T_RP);
				default: ;
			endcase
			last_cmd_n = n;
			last_op_m = op;
		end
		case (op)
			OP_ACT: begin
				gap = n - last_act_n;
				v.act_spacing = (gap <= ((ca[10:9] == last_grp_m) ? T_RRD_L : T_RRD_S));
				last_act_n = n;
				last_grp_m = ca[10:9];
				open_m[ca[8:6]] = 1'b1;
			end
			OP_PRE: open_m[ca[8:6]] = 1'b0;
			OP_RD: begin
				v.closed_bank_read = !open_m[ca[8:6]];
				rd_m[n] = 1'b1;
				rd_code_m[n] = pre_code_m;
			end
			OP_MRW: begin
				mrw_pend_m = 1'b1;
				mrw_addr_m = ca[12:5];
			end
			default: ;
		endcase
		// Window of a read RL samples back closes here
		if (n >= RL && rd_m[n-RL]) begin
			code = rd_code_m[n-RL];
			mask = 8'hff >> (8 - pre_len(code));
			v.preamble = ((dqs_m & mask) != pre_pat(code));
		end
		return v;
	endfunction

	task automatic check_viol(input violation_t exp_v, input violation_t act_v);
		if (act_v !== exp_v) begin
			err_cnt++;
			$display("mismatch %s cycle %0d: expected %b actual %b",
				test_name, cyc, exp_v, act_v);
		end
	endtask

	// ----------------------------------------
	// Bus drivers on the falling edge
	// ----------------------------------------
	task automatic step(input logic cs_n, input ca_t ca);
		int s;
		@(negedge dfi_phy_clk);
		s = cyc + 1;
		cs_n_i = cs_n;
		ca_i = ca;
		dqs_i = dqs_sched[s];
		exp_arr[s] = ref_step(s, cs_n, ca, dqs_sched[s]);
	endtask

	task automatic idle(input int n);
		repeat (n) step(1'b1, '0);
	endtask

	task automatic send(input cmd_op_e op, input bank_t bank, input bank_grp_t grp);
		ca_t ca;
		ca = '0;
		ca[8:6] = bank;
		case (op)
			OP_MRR: ca[4:0] = OPC_MRR;
			OP_PRE: ca[4:0] = OPC_PRE;
			OP_RD: ca[4:0] = OPC_RD;
			default: begin
				// ACT keeps the low opcode bits at 00
				ca[10:9] = grp;
			end
		endcase
		step(1'b0, ca);
	endtask

	task automatic mrw(input mr_addr_t addr, input mr_op_t op);
		ca_t ca;
		ca = '0;
		ca[12:5] = addr;
		ca[4:0] = OPC_MRW;
		step(1'b0, ca);
		// Operand cycle with CS left high
		step(1'b1, {6'b0, op});
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = err_cnt;
		test_t0 = cyc;
	endtask

	// Pad to a fixed length so late flags land inside the test
	task automatic finish_test(input int len);
		while (cyc < test_t0 + len) begin
			idle(1);
		end
		if (err_cnt == test_err0) begin
			pass_cnt++;
			$display("test %s: ok", test_name);
		end else begin
			fail_cnt++;
			$display("test %s: FAILED with %0d errors", test_name, err_cnt - test_err0);
		end
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic spacing_gaps();
		for (int gap = 1; gap <= 7; gap++) begin
			send(OP_MRR, 3'd0, 2'd0);
			idle(gap - 1);
			send(OP_PRE, 3'd0, 2'd0);
			idle(8);
			send(OP_PRE, 3'd1, 2'd0);
			idle(gap - 1);
			send(OP_MRR, 3'd0, 2'd0);
			idle(8);
		end
		// MRW gaps start at 2 because of the data cycle
		for (int gap = 2; gap <= 7; gap++) begin
			mrw(8'd1, 8'h00);
			idle(gap - 2);
			mrw(8'd1, 8'h00);
			idle(8);
			mrw(8'd1, 8'h00);
			idle(gap - 2);
			send(OP_MRR, 3'd0, 2'd0);
			idle(8);
		end
	endtask

	task automatic act_pairs();
		bank_grp_t g1;
		bank_grp_t g2;
		int gap;
		for (int i = 0; i < 24; i++) begin
			g1 = bank_grp_t'(rand_bits(2));
			if (rand_bits(1) == 1) begin
				g2 = g1;
			end else begin
				g2 = g1 ^ bank_grp_t'(1 + rand_bits(1));
			end
			gap = 1 + rand_bits(3);
			send(OP_ACT, bank_t'(rand_bits(3)), g1);
			idle(gap - 1);
			send(OP_ACT, bank_t'(rand_bits(3)), g2);
			idle(6);
		end
	endtask

	task automatic bank_mix();
		int kind;
		bank_t b;
		for (int i = 0; i < 60; i++) begin
			kind = rand_bits(2);
			b = bank_t'(rand_bits(3));
			case (kind)
				0: send(OP_ACT, b, 2'd0);
				1: send(OP_PRE, b, 2'd0);
				default: send(OP_RD, b, 2'd0);
			endcase
			idle(rand_bits(2));
		end
	endtask

	task automatic mode_reg_writes();
		mr_addr_t addr;
		for (int i = 0; i < 24; i++) begin
			case (rand_bits(2))
				0: addr = 8'h00;
				1: addr = 8'h08;
				2: addr = 8'h28;
				default: addr = mr_addr_t'(rand_bits(8));
			endcase
			mrw(addr, mr_op_t'(rand_bits(8)));
			// Clear of tMRD before the next write
			idle(6);
		end
	endtask

	task automatic preamble_reads();
		int len;
		int s;
		int flip;
		logic [7:0] pat;
		send(OP_ACT, 3'd0, 2'd0);
		idle(4);
		for (int code = 0; code < 5; code++) begin
			// Next MR8 write lands while the last reads are still in flight
			mrw(8'd8, mr_op_t'(code));
			idle(6);
			len = pre_len(pre_code_t'(code));
			pat = pre_pat(pre_code_t'(code));
			for (int r = 0; r < 4; r++) begin
				send(OP_RD, 3'd0, 2'd0);
				s = cyc + 1;
				// Bit k of the pattern is k samples before the last
				for (int k = 0; k < len; k++) begin
					dqs_sched[s + RL - k] = pat[k];
				end
				if (rand_bits(1) == 1) begin
					flip = rand_bits(3) % len;
					dqs_sched[s + RL - flip] = !dqs_sched[s + RL - flip];
				end
				idle(len);
			end
		end
		idle(RL + 4);
	endtask

	// ----------------------------------------
	// Compare, timeout and main sequence
	// ----------------------------------------
	always @(negedge dfi_phy_clk) begin
		if (cyc > RST_CYCLES) begin
			check_viol(exp_arr[cyc - 2], viol_o);
		end
	end

	always @(posedge dfi_phy_clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYC) begin
			$display("timeout: tests still running after %0d cycles", TIMEOUT_CYC);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		cs_n_i = 1'b1;
		ca_i = '0;
		dqs_i = 1'b0;
		lfsr = 32'd70467;
		err_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		mrw_pend_m = 1'b0;
		mrw_addr_m = '0;
		last_cmd_n = -100;
		last_op_m = OP_NONE;
		last_act_n = -100;
		last_grp_m = '0;
		open_m = '0;
		pre_code_m = '0;
		dqs_m = '0;
		for (int i = 0; i < MAX_CYC; i++) begin
			exp_arr[i] = '0;
			dqs_sched[i] = 1'b0;
			rd_m[i] = 1'b0;
			rd_code_m[i] = '0;
		end
		wait (rst_n_i === 1'b1);
		start_test("spacing");
		spacing_gaps();
		finish_test(LEN_SPACING);
		start_test("act_timing");
		act_pairs();
		finish_test(LEN_ACT);
		start_test("bank_state");
		bank_mix();
		finish_test(LEN_BANK);
		start_test("rfu_write");
		mode_reg_writes();
		finish_test(LEN_RFU);
		start_test("read_preamble");
		preamble_reads();
		finish_test(LEN_PRE);
		$display("summary: %0d tests passed, %0d failed, %0d mismatches",
			pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
design/dfi_mon_pkg.sv
design/dfi_cmd_decode.sv
design/dfi_cmd_spacing.sv
design/dfi_bank_tracker.sv
design/dfi_mode_reg.sv
design/dfi_rd_preamble_check.sv
design/dfi_protocol_monitor.sv
test/tb_clk_gen.sv
test/tb_dfi_protocol_monitor.sv

// ==== Bender.yml ====
package:
  name: dfi_protocol_monitor

sources:
  - design/dfi_mon_pkg.sv
  - design/dfi_cmd_decode.sv
  - design/dfi_cmd_spacing.sv
  - design/dfi_bank_tracker.sv
  - design/dfi_mode_reg.sv
  - design/dfi_rd_preamble_check.sv
  - design/dfi_protocol_monitor.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_dfi_protocol_monitor.sv
